// File: common/fpu_macros.svh
`ifndef FPU_MACROS_SVH
`define FPU_MACROS_SVH

// Single-precision word layout
`define FPU_WORD_W 32
`define FPU_EXP_W  8
`define FPU_FRAC_W 23

// Exponent value shared by infinity and NaN
`define FPU_EXP_ONES 8'hFF

// Canonical quiet NaN returned for every NaN result
`define FPU_QNAN 32'h7FC0_0000

`endif

// File: common/fpu_pkg.sv
`default_nettype none

`include "fpu_macros.svh"

package fpu_pkg;

    // Field view of a single-precision word
    typedef struct packed {
        logic                   sign;
        logic [`FPU_EXP_W-1:0]  exp;
        logic [`FPU_FRAC_W-1:0] frac;
    } fp32_fields_t;

    // Same word, read either as raw bits or as fields
    typedef union packed {
        logic [`FPU_WORD_W-1:0] bits;
        fp32_fields_t           f;
    } fp32_u;

    // Operation codes, 2'b11 is reserved
    typedef enum logic [1:0] {
        MDS_MUL  = 2'b00,
        MDS_DIV  = 2'b01,
        MDS_SQRT = 2'b10,
        MDS_RSVD = 2'b11
    } mds_op_e;

    // Result mux select
    typedef enum logic [1:0] {
        SRC_MULDIV = 2'b00,
        SRC_DIV    = 2'b01,
        SRC_SQRT   = 2'b10
    } result_src_e;

    typedef enum logic [2:0] {
        IDLE, DIV_WAIT, DIV_OUT, MUL1, MUL2, MUL_OUT, SQRT_WAIT, SQRT_OUT
    } mds_state_e;

endpackage

`default_nettype wire

// File: mds/fpu_mds_ctrl.sv
`default_nettype none

module fpu_mds_ctrl (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  fpu_pkg::mds_op_e     op_sel,
    input  fpu_pkg::fp32_u       op_a,
    input  fpu_pkg::fp32_u       op_b,
    input  logic                 div_rdy,
    input  logic                 sqrt_rdy,
    output fpu_pkg::fp32_u       fast_res,
    output logic                 fast_sel,
    output logic                 invalid,
    output logic                 div_by_zero,
    output logic                 div_start,
    output logic                 sqrt_start,
    output logic                 result_reg_en,
    output logic                 done,
    output fpu_pkg::result_src_e result_sel
);

    // Operand classes
    logic zero_a, zero_b;
    logic inf_a, inf_b;
    logic nan_a, nan_b;
    logic snan_a, snan_b;
    logic sign_a, sign_b;

    logic fast_hit;

    fpu_operand_class class_i (
        .op_a   (op_a),
        .op_b   (op_b),
        .zero_a (zero_a),
        .zero_b (zero_b),
        .inf_a  (inf_a),
        .inf_b  (inf_b),
        .nan_a  (nan_a),
        .nan_b  (nan_b),
        .snan_a (snan_a),
        .snan_b (snan_b),
        .sign_a (sign_a),
        .sign_b (sign_b)
    );

    fpu_special_case special_i (
        .op_sel      (op_sel),
        .zero_a      (zero_a),
        .zero_b      (zero_b),
        .inf_a       (inf_a),
        .inf_b       (inf_b),
        .nan_a       (nan_a),
        .nan_b       (nan_b),
        .snan_a      (snan_a),
        .snan_b      (snan_b),
        .sign_a      (sign_a),
        .sign_b      (sign_b),
        .fast_res    (fast_res),
        .fast_hit    (fast_hit),
        .invalid     (invalid),
        .div_by_zero (div_by_zero)
    );

    fpu_mds_sequencer seq_i (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .fast_hit      (fast_hit),
        .op_sel        (op_sel),
        .div_rdy       (div_rdy),
        .sqrt_rdy      (sqrt_rdy),
        .div_start     (div_start),
        .sqrt_start    (sqrt_start),
        .result_reg_en (result_reg_en),
        .done          (done),
        .result_sel    (result_sel)
    );

    // Host picks the fast result whenever the table hits
    assign fast_sel = fast_hit;

endmodule

`default_nettype wire

// File: mds/fpu_mds_sequencer.sv
`default_nettype none

module fpu_mds_sequencer (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  logic                 fast_hit,
    input  fpu_pkg::mds_op_e     op_sel,
    input  logic                 div_rdy,
    input  logic                 sqrt_rdy,
    output logic                 div_start,
    output logic                 sqrt_start,
    output logic                 result_reg_en,
    output logic                 done,
    output fpu_pkg::result_src_e result_sel
);

    import fpu_pkg::*;

    mds_state_e state;
    mds_state_e state_nxt;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Mealy decode, the handshake outputs react to start and ready directly
    always_comb begin
        state_nxt     = state;
        div_start     = 1'b0;
        sqrt_start    = 1'b0;
        result_reg_en = 1'b0;
        done          = 1'b0;
        result_sel    = SRC_MULDIV;

        case (state)
            IDLE: begin
                if (start) begin
                    if (fast_hit) begin
                        // Special case finishes in the start cycle
                        result_reg_en = 1'b1;
                        done          = 1'b1;
                    end else begin
                        case (op_sel)
                            MDS_MUL:  state_nxt = MUL1;
                            MDS_DIV:  state_nxt = DIV_WAIT;
                            MDS_SQRT: state_nxt = SQRT_WAIT;
                            default:  state_nxt = IDLE;
                        endcase
                    end
                end
            end

            MUL1: begin
                state_nxt = MUL2;
            end

            MUL2: begin
                result_reg_en = 1'b1;
                state_nxt     = MUL_OUT;
            end

            MUL_OUT: begin
                result_reg_en = 1'b1;
                done          = 1'b1;
                state_nxt     = IDLE;
            end

            DIV_WAIT: begin
                if (div_rdy) begin
                    result_reg_en = 1'b1;
                    state_nxt     = DIV_OUT;
                end else begin
                    div_start = 1'b1;
                end
            end

            DIV_OUT: begin
                done       = 1'b1;
                result_sel = SRC_DIV;
                state_nxt  = IDLE;
            end

            SQRT_WAIT: begin
                if (sqrt_rdy) begin
                    result_reg_en = 1'b1;
                    state_nxt     = SQRT_OUT;
                end else begin
                    sqrt_start = 1'b1;
                end
            end

            SQRT_OUT: begin
                done       = 1'b1;
                result_sel = SRC_SQRT;
                state_nxt  = IDLE;
            end

            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: mds/fpu_operand_class.sv
`default_nettype none

`include "fpu_macros.svh"

module fpu_operand_class (
    input  fpu_pkg::fp32_u op_a,
    input  fpu_pkg::fp32_u op_b,
    output logic           zero_a,
    output logic           zero_b,
    output logic           inf_a,
    output logic           inf_b,
    output logic           nan_a,
    output logic           nan_b,
    output logic           snan_a,
    output logic           snan_b,
    output logic           sign_a,
    output logic           sign_b
);

    logic exp_zero_a, exp_zero_b;
    logic exp_ones_a, exp_ones_b;
    logic frac_zero_a, frac_zero_b;

    assign exp_zero_a  = (op_a.f.exp == '0);
    assign exp_zero_b  = (op_b.f.exp == '0);
    assign exp_ones_a  = (op_a.f.exp == `FPU_EXP_ONES);
    assign exp_ones_b  = (op_b.f.exp == `FPU_EXP_ONES);
    assign frac_zero_a = (op_a.f.frac == '0);
    assign frac_zero_b = (op_b.f.frac == '0);

    // Subnormals fall through as finite
    assign zero_a = exp_zero_a & frac_zero_a;
    assign zero_b = exp_zero_b & frac_zero_b;
    assign inf_a  = exp_ones_a & frac_zero_a;
    assign inf_b  = exp_ones_b & frac_zero_b;
    assign nan_a  = exp_ones_a & ~frac_zero_a;
    assign nan_b  = exp_ones_b & ~frac_zero_b;

    // Quiet bit is the top fraction bit
    assign snan_a = nan_a & ~op_a.f.frac[`FPU_FRAC_W-1];
    assign snan_b = nan_b & ~op_b.f.frac[`FPU_FRAC_W-1];

    assign sign_a = op_a.f.sign;
    assign sign_b = op_b.f.sign;

endmodule

`default_nettype wire

// File: mds/fpu_special_case.sv
`default_nettype none

`include "fpu_macros.svh"

module fpu_special_case (
    input  fpu_pkg::mds_op_e op_sel,
    input  logic             zero_a,
    input  logic             zero_b,
    input  logic             inf_a,
    input  logic             inf_b,
    input  logic             nan_a,
    input  logic             nan_b,
    input  logic             snan_a,
    input  logic             snan_b,
    input  logic             sign_a,
    input  logic             sign_b,
    output fpu_pkg::fp32_u   fast_res,
    output logic             fast_hit,
    output logic             invalid,
    output logic             div_by_zero
);

    import fpu_pkg::*;

    logic prod_sign;

    function automatic fp32_u signed_inf(input logic s);
        fp32_u w;
        w.f.sign = s;
        w.f.exp  = `FPU_EXP_ONES;
        w.f.frac = '0;
        return w;
    endfunction

    function automatic fp32_u signed_zero(input logic s);
        fp32_u w;
        w.f.sign = s;
        w.f.exp  = '0;
        w.f.frac = '0;
        return w;
    endfunction

    assign prod_sign = sign_a ^ sign_b;

    always_comb begin
        fast_res.bits = '0;
        fast_hit      = 1'b0;
        invalid       = 1'b0;
        div_by_zero   = 1'b0;

        case (op_sel)
            MDS_MUL, MDS_DIV: begin
                // A NaN wins over B, both collapse to the canonical NaN
                if (nan_a || nan_b) begin
                    fast_hit      = 1'b1;
                    fast_res.bits = `FPU_QNAN;
                    invalid       = snan_a | snan_b;
                end else if (op_sel == MDS_MUL) begin
                    if ((zero_a && inf_b) || (inf_a && zero_b)) begin
                        fast_hit      = 1'b1;
                        fast_res.bits = `FPU_QNAN;
                        invalid       = 1'b1;
                    end else if (inf_a || inf_b) begin
                        fast_hit = 1'b1;
                        fast_res = signed_inf(prod_sign);
                    end else if (zero_a || zero_b) begin
                        fast_hit = 1'b1;
                        fast_res = signed_zero(prod_sign);
                    end
                end else begin
                    // Divide
                    if ((zero_a && zero_b) || (inf_a && inf_b)) begin
                        fast_hit      = 1'b1;
                        fast_res.bits = `FPU_QNAN;
                        invalid       = 1'b1;
                        div_by_zero   = zero_b;
                    end else if (zero_b) begin
                        fast_hit    = 1'b1;
                        fast_res    = signed_inf(prod_sign);
                        div_by_zero = 1'b1;
                    end else if (inf_a) begin
                        fast_hit = 1'b1;
                        fast_res = signed_inf(prod_sign);
                    end else if (zero_a || inf_b) begin
                        fast_hit = 1'b1;
                        fast_res = signed_zero(prod_sign);
                    end
                end
            end
            MDS_SQRT: begin
                // Operand B plays no part here
                if (nan_a) begin
                    fast_hit      = 1'b1;
                    fast_res.bits = `FPU_QNAN;
                    invalid       = snan_a;
                end else if (zero_a) begin
                    fast_hit = 1'b1;
                    fast_res = signed_zero(sign_a);
                end else if (sign_a) begin
                    fast_hit      = 1'b1;
                    fast_res.bits = `FPU_QNAN;
                    invalid       = 1'b1;
                end else if (inf_a) begin
                    fast_hit = 1'b1;
                    fast_res = signed_inf(1'b0);
                end
            end
            default: begin
                // Reserved opcode, never a fast result
                fast_hit = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+common
common/fpu_pkg.sv
mds/fpu_operand_class.sv
mds/fpu_special_case.sv
mds/fpu_mds_sequencer.sv
mds/fpu_mds_ctrl.sv
test/fpu_mds_ctrl_checker.sv
test/fpu_mds_ctrl_tb.sv

// File: test/fpu_mds_ctrl_checker.sv
`default_nettype none

module fpu_mds_ctrl_checker (
    input logic                clk,
    input logic                reset,
    input logic                start,
    input fpu_pkg::mds_op_e    op_sel,
    input logic                div_rdy,
    input logic                sqrt_rdy,
    input logic                div_start,
    input logic                sqrt_start,
    input logic                result_reg_en,
    input logic                done,
    input fpu_pkg::mds_state_e state
);

    import fpu_pkg::*;

    // Number of failed assertions, read by the testbench at the end of the run
    int fail_count = 0;

    // Reserved opcode is never issued
    assert property (@(posedge clk) disable iff (!reset) start |-> op_sel != MDS_RSVD)
        else begin
            $error("start raised with the reserved opcode");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!reset) done |=> !done)
        else begin
            $error("done held high for more than one cycle");
            fail_count++;
        end

    // Only one iterative unit runs at a time
    assert property (@(posedge clk) disable iff (!reset) !(div_start && sqrt_start))
        else begin
            $error("div_start and sqrt_start high together");
            fail_count++;
        end

    // Ready counts only while the matching unit is waited on
    assert property (@(posedge clk) disable iff (!reset)
        ((state == DIV_WAIT) && div_rdy) || ((state == SQRT_WAIT) && sqrt_rdy)
        |-> result_reg_en)
        else begin
            $error("ready accepted without result_reg_en");
            fail_count++;
        end

endmodule

`default_nettype wire

// File: test/fpu_mds_ctrl_tb.sv
`default_nettype none

`include "fpu_macros.svh"

module fpu_mds_ctrl_tb;

    import fpu_pkg::*;

    logic        clk;
    logic        reset;
    logic        start;
    mds_op_e     op_sel;
    fp32_u       op_a;
    fp32_u       op_b;
    logic        div_rdy;
    logic        sqrt_rdy;
    fp32_u       fast_res;
    logic        fast_sel;
    logic        invalid;
    logic        div_by_zero;
    logic        div_start;
    logic        sqrt_start;
    logic        result_reg_en;
    logic        done;
    result_src_e result_sel;

    int check_count = 0;
    int error_count = 0;

    fpu_mds_ctrl dut_i (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .op_sel        (op_sel),
        .op_a          (op_a),
        .op_b          (op_b),
        .div_rdy       (div_rdy),
        .sqrt_rdy      (sqrt_rdy),
        .fast_res      (fast_res),
        .fast_sel      (fast_sel),
        .invalid       (invalid),
        .div_by_zero   (div_by_zero),
        .div_start     (div_start),
        .sqrt_start    (sqrt_start),
        .result_reg_en (result_reg_en),
        .done          (done),
        .result_sel    (result_sel)
    );

    bind fpu_mds_ctrl fpu_mds_ctrl_checker checker_i (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .op_sel        (op_sel),
        .div_rdy       (div_rdy),
        .sqrt_rdy      (sqrt_rdy),
        .div_start     (div_start),
        .sqrt_start    (sqrt_start),
        .result_reg_en (result_reg_en),
        .done          (done),
        .state         (seq_i.state)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Stub divider and square-root unit answering 1 to 6 cycles after start
    initial begin : ready_responder
        int unsigned delay;
        logic        is_div;
        div_rdy  = 1'b0;
        sqrt_rdy = 1'b0;
        delay    = $urandom(26);
        forever begin
            @(negedge clk);
            if (div_start || sqrt_start) begin
                is_div = div_start;
                delay  = 1 + ($urandom % 6);
                repeat (delay) @(posedge clk);
                #1;
                if (is_div) begin
                    div_rdy = 1'b1;
                end else begin
                    sqrt_rdy = 1'b1;
                end
                @(posedge clk);
                #1;
                div_rdy  = 1'b0;
                sqrt_rdy = 1'b0;
            end
        end
    end

    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            error_count++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    // No activity expected with start low in IDLE
    task automatic idle_check();
        @(negedge clk);
        compare("done", done, 1'b0);
        compare("result_reg_en", result_reg_en, 1'b0);
        compare("div_start", div_start, 1'b0);
        compare("sqrt_start", sqrt_start, 1'b0);
        step_cycle();
    endtask

    task automatic fast_case(input mds_op_e op, input logic [31:0] a, input logic [31:0] b,
                             input logic [31:0] exp_res, input logic exp_inv,
                             input logic exp_dbz);
        op_sel    = op;
        op_a.bits = a;
        op_b.bits = b;
        start     = 1'b1;
        @(negedge clk);
        compare("done", done, 1'b1);
        compare("fast_sel", fast_sel, 1'b1);
        compare("result_reg_en", result_reg_en, 1'b1);
        compare("result_sel", result_sel, SRC_MULDIV);
        compare("fast_res", fast_res.bits, exp_res);
        compare("invalid", invalid, exp_inv);
        compare("div_by_zero", div_by_zero, exp_dbz);
        step_cycle();
        start = 1'b0;
        idle_check();
    endtask

    // 3.0 times 2.0 through the two-stage path
    task automatic mul_sequence();
        int   cyc;
        logic seen_done;
        cyc       = 0;
        seen_done = 1'b0;
        op_sel    = MDS_MUL;
        op_a.bits = 32'h4040_0000;
        op_b.bits = 32'h4000_0000;
        start     = 1'b1;
        @(negedge clk);
        compare("fast_sel", fast_sel, 1'b0);
        compare("done", done, 1'b0);
        step_cycle();
        start = 1'b0;
        while (!seen_done && cyc < 50) begin
            cyc++;
            @(negedge clk);
            compare("result_reg_en", result_reg_en, (cyc == 2) || (cyc == 3));
            compare("div_start", div_start, 1'b0);
            compare("sqrt_start", sqrt_start, 1'b0);
            seen_done = done;
            if (done) begin
                compare("done latency", cyc, 3);
                compare("result_sel", result_sel, SRC_MULDIV);
            end
            step_cycle();
        end
        assert (seen_done) else begin
            error_count++;
            $display("timeout waiting for done after multiply start");
        end
        idle_check();
    endtask

    task automatic iter_handshake(input mds_op_e op);
        int          cyc;
        logic        got_rdy;
        result_src_e exp_src;
        cyc       = 0;
        got_rdy   = 1'b0;
        exp_src   = (op == MDS_DIV) ? SRC_DIV : SRC_SQRT;
        op_sel    = op;
        op_a.bits = 32'h40C0_0000;
        op_b.bits = 32'h4000_0000;
        start     = 1'b1;
        @(negedge clk);
        compare("fast_sel", fast_sel, 1'b0);
        compare("done", done, 1'b0);
        step_cycle();
        start = 1'b0;
        while (!got_rdy && cyc < 50) begin
            cyc++;
            @(negedge clk);
            got_rdy = (op == MDS_DIV) ? div_rdy : sqrt_rdy;
            // Start drops in the ready cycle itself
            compare("div_start", div_start, (op == MDS_DIV) && !got_rdy);
            compare("sqrt_start", sqrt_start, (op == MDS_SQRT) && !got_rdy);
            compare("result_reg_en", result_reg_en, got_rdy);
            compare("done", done, 1'b0);
            step_cycle();
        end
        assert (got_rdy) else begin
            error_count++;
            $display("timeout waiting for ready from the iterative unit");
        end
        @(negedge clk);
        compare("done", done, 1'b1);
        compare("result_sel", result_sel, exp_src);
        compare("result_reg_en", result_reg_en, 1'b0);
        step_cycle();
        idle_check();
    endtask

    initial begin
        reset     = 1'b0;
        start     = 1'b0;
        op_sel    = MDS_MUL;
        op_a.bits = '0;
        op_b.bits = '0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b1;
        idle_check();

        // Multiply special cases
        fast_case(MDS_MUL, 32'h0000_0000, 32'h7F80_0000, `FPU_QNAN, 1'b1, 1'b0);
        fast_case(MDS_MUL, 32'h8000_0000, 32'h40A0_0000, 32'h8000_0000, 1'b0, 1'b0);
        fast_case(MDS_MUL, 32'h7F80_0000, 32'hC000_0000, 32'hFF80_0000, 1'b0, 1'b0);
        fast_case(MDS_MUL, 32'h7FC0_0000, 32'h3F80_0000, `FPU_QNAN, 1'b0, 1'b0);
        fast_case(MDS_MUL, 32'h7F80_0001, 32'h0000_0000, `FPU_QNAN, 1'b1, 1'b0);

        // Divide special cases
        fast_case(MDS_DIV, 32'h0000_0000, 32'h0000_0000, `FPU_QNAN, 1'b1, 1'b1);
        fast_case(MDS_DIV, 32'h4040_0000, 32'h0000_0000, 32'h7F80_0000, 1'b0, 1'b1);
        fast_case(MDS_DIV, 32'hFF80_0000, 32'h0000_0000, 32'hFF80_0000, 1'b0, 1'b1);
        fast_case(MDS_DIV, 32'h7F80_0000, 32'h7F80_0000, `FPU_QNAN, 1'b1, 1'b0);
        fast_case(MDS_DIV, 32'h0000_0000, 32'hFF80_0000, 32'h8000_0000, 1'b0, 1'b0);
        fast_case(MDS_DIV, 32'h3F80_0000, 32'h7F80_0001, `FPU_QNAN, 1'b1, 1'b0);

        // Square-root special cases with B ignored
        fast_case(MDS_SQRT, 32'h8000_0000, 32'h3F80_0000, 32'h8000_0000, 1'b0, 1'b0);
        fast_case(MDS_SQRT, 32'h7F80_0000, 32'h3F80_0000, 32'h7F80_0000, 1'b0, 1'b0);
        fast_case(MDS_SQRT, 32'hFF80_0000, 32'h3F80_0000, `FPU_QNAN, 1'b1, 1'b0);
        fast_case(MDS_SQRT, 32'hC080_0000, 32'h3F80_0000, `FPU_QNAN, 1'b1, 1'b0);
        fast_case(MDS_SQRT, 32'h7F80_0001, 32'h3F80_0000, `FPU_QNAN, 1'b1, 1'b0);

        mul_sequence();
        mul_sequence();

        repeat (4) begin
            iter_handshake(MDS_DIV);
            iter_handshake(MDS_SQRT);
        end

        // Concurrent assertion failures from the bound checker
        error_count += dut_i.checker_i.fail_count;

        $display("checks %0d errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
